//--- hdl/cap_pkg.sv
/*
 * Capability metadata format
 * Field widths, the per-register metadata struct and the null capability
 */

`default_nettype none

package cap_pkg;

  ////////////////////
  // Field widths
  ////////////////////

  localparam int unsigned CapPermsW = 6;
  localparam int unsigned CapOtypeW = 3;

  // Metadata kept beside each register, 10 bits
  typedef struct packed {
    logic                 tag;
    logic [CapPermsW-1:0] perms;
    logic [CapOtypeW-1:0] otype;
  } reg_cap_t;

  // Untagged, no permissions, unsealed
  localparam reg_cap_t NullCap = '{tag: 1'b0, perms: '0, otype: '0};

endpackage

`default_nettype wire

//--- hdl/rf_pkg.sv
/*
 * Register file port definitions
 * Strobe structs for writeback, reservation and revocation, the merged
 * write request and the read result
 */

`default_nettype none

package rf_pkg;

  localparam int unsigned RegDataW = 32;
  // Enough for 16 or 32 registers
  localparam int unsigned RegAddrW = 5;

  ////////////////////
  // Input strobes
  ////////////////////

  typedef struct packed {
    logic                valid;
    logic [RegAddrW-1:0] addr;
    logic [RegDataW-1:0] data;
    cap_pkg::reg_cap_t   cap;
  } rf_wb_t;

  typedef struct packed {
    logic                valid;
    logic [RegAddrW-1:0] addr;
  } rf_rsv_t;

  typedef struct packed {
    logic                valid;
    logic [RegAddrW-1:0] addr;
    logic                clrtag;
  } rf_rvk_t;

  ////////////////////
  // Internal write port
  ////////////////////

  typedef enum logic [1:0] {
    WrNone   = 2'd0,
    WrData   = 2'd1,
    WrRevoke = 2'd2
  } wr_kind_e;

  typedef struct packed {
    wr_kind_e            kind;
    logic [RegAddrW-1:0] addr;
    logic [RegDataW-1:0] data;
    cap_pkg::reg_cap_t   cap;
    logic                clrtag;
  } rf_wr_req_t;

  typedef struct packed {
    logic [RegDataW-1:0] data;
    cap_pkg::reg_cap_t   cap;
  } rf_rd_t;

endpackage

`default_nettype wire

//--- hdl/capreg_bank.sv
/*
 * Capability register bank
 * Holds data, metadata and a ready bit per register, serves two
 * combinational read ports and applies the merged write request
 */

`timescale 1ns/1ps
`default_nettype none

module capreg_bank #(
  parameter int unsigned NumRegs = 32
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire rf_pkg::rf_wr_req_t             wr_req_i,
  input  wire rf_pkg::rf_rsv_t                rsv_i,
  input  wire logic [rf_pkg::RegAddrW-1:0]    raddr_a_i,
  input  wire logic [rf_pkg::RegAddrW-1:0]    raddr_b_i,
  output rf_pkg::rf_rd_t                      rdata_a_o,
  output rf_pkg::rf_rd_t                      rdata_b_o,
  output logic [NumRegs-1:0]                  reg_rdy_o
);

  import rf_pkg::*;
  import cap_pkg::*;

  logic [RegDataW-1:0] data_all [NumRegs];
  reg_cap_t            cap_all  [NumRegs];

  ////////////////////
  // Storage
  ////////////////////

  for (genvar i = 0; i < NumRegs; i++) begin : g_reg
    if (i == 0) begin : g_zero
      // Hardwired zero, always ready
      assign data_all[i]  = '0;
      assign cap_all[i]   = NullCap;
      assign reg_rdy_o[i] = 1'b1;
    end else begin : g_store
      localparam logic [RegAddrW-1:0] Idx = RegAddrW'(i);

      logic [RegDataW-1:0] data_q;
      reg_cap_t            cap_q;
      logic                rdy_q;
      logic                wr_data;
      logic                wr_rvk;
      logic                rsv_hit;

      assign wr_data = (wr_req_i.kind == WrData)   && (wr_req_i.addr == Idx);
      assign wr_rvk  = (wr_req_i.kind == WrRevoke) && (wr_req_i.addr == Idx);
      assign rsv_hit = rsv_i.valid && (rsv_i.addr == Idx);

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          data_q <= '0;
          cap_q  <= NullCap;
          rdy_q  <= 1'b1;
        end else begin
          if (wr_data) begin
            data_q <= wr_req_i.data;
            cap_q  <= wr_req_i.cap;
          end else if (wr_rvk && wr_req_i.clrtag) begin
            // Only the tag goes, perms and otype stay
            cap_q.tag <= 1'b0;
          end
          // Reservation wins over a same-cycle write
          if (rsv_hit) begin
            rdy_q <= 1'b0;
          end else if (wr_data || wr_rvk) begin
            rdy_q <= 1'b1;
          end
        end
      end

      assign data_all[i]  = data_q;
      assign cap_all[i]   = cap_q;
      assign reg_rdy_o[i] = rdy_q;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // Addresses beyond NumRegs read as zero
  function automatic rf_rd_t read_reg(input logic [RegAddrW-1:0] addr);
    rf_rd_t rd;
    rd.data = '0;
    rd.cap  = NullCap;
    for (int k = 0; k < NumRegs; k++) begin
      if (addr == RegAddrW'(k)) begin
        rd.data = data_all[k];
        rd.cap  = cap_all[k];
      end
    end
    return rd;
  endfunction

  always_comb begin
    rdata_a_o = read_reg(raddr_a_i);
    rdata_b_o = read_reg(raddr_b_i);
  end

endmodule

`default_nettype wire

//--- hdl/capreg_revoke_queue.sv
/*
 * Revocation queue
 * Buffers revocation strobes and merges them with writebacks onto the
 * single register write port, writeback first
 */

`timescale 1ns/1ps
`default_nettype none

module capreg_revoke_queue #(
  parameter int unsigned RvkDepth = 4
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire rf_pkg::rf_wb_t     wb_i,
  input  wire rf_pkg::rf_rvk_t    rvk_i,
  output rf_pkg::rf_wr_req_t      wr_req_o,
  output logic                    rvk_overflow_o
);

  import rf_pkg::*;
  import cap_pkg::*;

  localparam int unsigned PtrW = (RvkDepth > 1) ? $clog2(RvkDepth) : 1;
  localparam int unsigned CntW = $clog2(RvkDepth + 1);

  // Queued revocation, the valid bit is implied by the count
  typedef struct packed {
    logic [RegAddrW-1:0] addr;
    logic                clrtag;
  } rvk_ent_t;

  rvk_ent_t        mem_q [RvkDepth];
  rvk_ent_t        head;
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [CntW-1:0] cnt_q;
  logic            empty;
  logic            full;
  logic            push;
  logic            pop;
  logic            overflow_q;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] nxt;
    if (ptr == PtrW'(RvkDepth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == CntW'(RvkDepth));
  assign head  = mem_q[rptr_q];

  // Port is free only without a writeback
  assign pop  = ~wb_i.valid & ~empty;
  // A pop in the same cycle makes room for the new strobe
  assign push = rvk_i.valid & (~full | pop);

  ////////////////////
  // Queue state
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      cnt_q      <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push) begin
        wptr_q <= next_ptr(wptr_q);
      end
      if (pop) begin
        rptr_q <= next_ptr(rptr_q);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
      // One-cycle pulse, the strobe itself is dropped
      overflow_q <= rvk_i.valid & full & ~pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= '{addr: rvk_i.addr, clrtag: rvk_i.clrtag};
    end
  end

  assign rvk_overflow_o = overflow_q;

  ////////////////////
  // Write port merge
  ////////////////////

  always_comb begin
    wr_req_o.kind   = WrNone;
    wr_req_o.addr   = '0;
    wr_req_o.data   = '0;
    wr_req_o.cap    = NullCap;
    wr_req_o.clrtag = 1'b0;
    if (wb_i.valid) begin
      wr_req_o.kind = WrData;
      wr_req_o.addr = wb_i.addr;
      wr_req_o.data = wb_i.data;
      wr_req_o.cap  = wb_i.cap;
    end else if (!empty) begin
      // Head is issued and popped in this cycle
      wr_req_o.kind   = WrRevoke;
      wr_req_o.addr   = head.addr;
      wr_req_o.clrtag = head.clrtag;
    end
  end

endmodule

`default_nettype wire

//--- hdl/capreg_top.sv
/*
 * Capability register file subsystem
 * Revocation queue in front of the tagged register bank
 */

`timescale 1ns/1ps
`default_nettype none

module capreg_top #(
  parameter int unsigned NumRegs  = 32,
  parameter int unsigned RvkDepth = 4
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,

  // Write side strobes
  input  wire rf_pkg::rf_wb_t                 wb_i,
  input  wire rf_pkg::rf_rsv_t                rsv_i,
  input  wire rf_pkg::rf_rvk_t                rvk_i,

  // Read ports
  input  wire logic [rf_pkg::RegAddrW-1:0]    raddr_a_i,
  input  wire logic [rf_pkg::RegAddrW-1:0]    raddr_b_i,
  output rf_pkg::rf_rd_t                      rdata_a_o,
  output rf_pkg::rf_rd_t                      rdata_b_o,

  // Status
  output logic [NumRegs-1:0]                  reg_rdy_o,
  output logic                                rvk_overflow_o
);

  import rf_pkg::*;

  // Single write port into the bank
  rf_wr_req_t wr_req;

  ////////////////////
  // Revocation queue
  ////////////////////

  capreg_revoke_queue #(
    .RvkDepth (RvkDepth)
  ) u_revoke_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wb_i           (wb_i),
    .rvk_i          (rvk_i),
    .wr_req_o       (wr_req),
    .rvk_overflow_o (rvk_overflow_o)
  );

  ////////////////////
  // Register bank
  ////////////////////

  capreg_bank #(
    .NumRegs (NumRegs)
  ) u_bank (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_req_i  (wr_req),
    .rsv_i     (rsv_i),
    .raddr_a_i (raddr_a_i),
    .raddr_b_i (raddr_b_i),
    .rdata_a_o (rdata_a_o),
    .rdata_b_o (rdata_b_o),
    .reg_rdy_o (reg_rdy_o)
  );

endmodule

`default_nettype wire

//--- tests/capreg_checker.sv
/*
 * Testbench checker
 * Compares the DUT read ports, ready vector and overflow pulse with the
 * reference model on every clock edge out of reset
 */

`timescale 1ns/1ps
`default_nettype none

module capreg_checker #(
  parameter int unsigned NumRegs = 32
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire rf_pkg::rf_rd_t     rdata_a_i,
  input  wire rf_pkg::rf_rd_t     rdata_b_i,
  input  wire logic [NumRegs-1:0] reg_rdy_i,
  input  wire logic               ovf_i,
  input  wire rf_pkg::rf_rd_t     exp_a_i,
  input  wire rf_pkg::rf_rd_t     exp_b_i,
  input  wire logic [NumRegs-1:0] exp_rdy_i,
  input  wire logic               exp_ovf_i,
  output int unsigned             err_cnt_o,
  output int unsigned             chk_cnt_o
);

  int unsigned err_cnt = 0;
  int unsigned chk_cnt = 0;

  // Sampled ahead of the flop updates, so DUT and model show the same cycle
  always @(posedge clk_i) begin
    if (rst_ni) begin
      chk_cnt++;
      if (rdata_a_i !== exp_a_i) begin
        $display("** Error @ %0t: port A reads %h, expected %h", $time, rdata_a_i, exp_a_i);
        err_cnt++;
      end
      if (rdata_b_i !== exp_b_i) begin
        $display("** Error @ %0t: port B reads %h, expected %h", $time, rdata_b_i, exp_b_i);
        err_cnt++;
      end
      if (reg_rdy_i !== exp_rdy_i) begin
        $display("** Error @ %0t: ready vector %h, expected %h", $time, reg_rdy_i, exp_rdy_i);
        err_cnt++;
      end
      if (ovf_i !== exp_ovf_i) begin
        $display("** Error @ %0t: overflow flag %b, expected %b", $time, ovf_i, exp_ovf_i);
        err_cnt++;
      end
    end
  end

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

endmodule

`default_nettype wire

//--- tests/capreg_tb.sv
/*
 * Capability register file testbench
 * Clock, reset, random stimulus and a reference model of the register
 * bank and the revocation queue
 */

`timescale 1ns/1ps
`default_nettype none

module capreg_tb;

  import rf_pkg::*;
  import cap_pkg::*;

  localparam int unsigned NumRegs   = 32;
  localparam int unsigned RvkDepth  = 4;
  localparam int unsigned WaitLimit = 20;

  logic                clk_i;
  logic                rst_ni;
  rf_wb_t              wb;
  rf_rsv_t             rsv;
  rf_rvk_t             rvk;
  logic [RegAddrW-1:0] raddr_a;
  logic [RegAddrW-1:0] raddr_b;
  logic [RegAddrW-1:0] rd_next;
  rf_rd_t              rdata_a;
  rf_rd_t              rdata_b;
  logic [NumRegs-1:0]  reg_rdy;
  logic                rvk_ovf;
  int unsigned         err_cnt;
  int unsigned         chk_cnt;
  int unsigned         tmo_cnt;

  // Model state with queue entries of {addr, clrtag}
  logic [RegDataW-1:0] m_data [NumRegs];
  reg_cap_t            m_cap  [NumRegs];
  logic [NumRegs-1:0]  m_rdy;
  logic [RegAddrW:0]   m_q [$];
  logic                m_ovf;
  rf_rd_t              exp_a;
  rf_rd_t              exp_b;
  logic [NumRegs-1:0]  exp_rdy;
  logic                exp_ovf;

  capreg_top #(
    .NumRegs  (NumRegs),
    .RvkDepth (RvkDepth)
  ) UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wb_i           (wb),
    .rsv_i          (rsv),
    .rvk_i          (rvk),
    .raddr_a_i      (raddr_a),
    .raddr_b_i      (raddr_b),
    .rdata_a_o      (rdata_a),
    .rdata_b_o      (rdata_b),
    .reg_rdy_o      (reg_rdy),
    .rvk_overflow_o (rvk_ovf)
  );

  capreg_checker #(
    .NumRegs (NumRegs)
  ) u_checker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rdata_a_i (rdata_a),
    .rdata_b_i (rdata_b),
    .reg_rdy_i (reg_rdy),
    .ovf_i     (rvk_ovf),
    .exp_a_i   (exp_a),
    .exp_b_i   (exp_b),
    .exp_rdy_i (exp_rdy),
    .exp_ovf_i (exp_ovf),
    .err_cnt_o (err_cnt),
    .chk_cnt_o (chk_cnt)
  );

  always #50 clk_i = ~clk_i;

  // Expected read result with register 0 hardwired to zero
  function automatic rf_rd_t ref_read(input logic [RegAddrW-1:0] addr);
    rf_rd_t rd;
    rd.data = '0;
    rd.cap  = NullCap;
    if (addr != '0) begin
      rd.data = m_data[addr];
      rd.cap  = m_cap[addr];
    end
    return rd;
  endfunction

  function automatic rf_wb_t rand_wb(input logic [RegAddrW-1:0] addr);
    rf_wb_t w;
    w.valid     = 1'b1;
    w.addr      = addr;
    w.data      = $urandom;
    w.cap.tag   = 1'($urandom);
    w.cap.perms = CapPermsW'($urandom);
    w.cap.otype = CapOtypeW'($urandom);
    return w;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  always @(posedge clk_i) begin : model
    logic [RegAddrW:0] head;
    logic              pop;
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        m_data[i] = '0;
        m_cap[i]  = NullCap;
      end
      m_rdy = '1;
      m_q.delete();
      m_ovf = 1'b0;
    end else begin
      // Writeback owns the port and the queue head goes only in a free cycle
      pop  = !wb.valid && (m_q.size() != 0);
      head = '0;
      if (pop) begin
        head = m_q.pop_front();
      end
      m_ovf = rvk.valid && (m_q.size() == RvkDepth);
      if (rvk.valid && !m_ovf) begin
        m_q.push_back({rvk.addr, rvk.clrtag});
      end
      if (wb.valid && wb.addr != '0) begin
        m_data[wb.addr] = wb.data;
        m_cap[wb.addr]  = wb.cap;
        m_rdy[wb.addr]  = 1'b1;
      end else if (pop && head[RegAddrW:1] != '0) begin
        if (head[0]) begin
          m_cap[head[RegAddrW:1]].tag = 1'b0;
        end
        m_rdy[head[RegAddrW:1]] = 1'b1;
      end
      if (rsv.valid && rsv.addr != '0) begin
        m_rdy[rsv.addr] = 1'b0;
      end
    end
  end

  // Mid-cycle snapshot for the checker
  always @(negedge clk_i) begin
    exp_a   <= ref_read(raddr_a);
    exp_b   <= ref_read(raddr_b);
    exp_rdy <= m_rdy;
    exp_ovf <= m_ovf;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Port A reads back the last written register one cycle later
  task automatic drive_cycle(input rf_wb_t w, input rf_rsv_t r, input rf_rvk_t k);
    @(posedge clk_i);
    wb      <= w;
    rsv     <= r;
    rvk     <= k;
    raddr_a <= rd_next;
    raddr_b <= ($urandom_range(1) != 0) ? rd_next : RegAddrW'($urandom);
    rd_next = w.valid ? w.addr : RegAddrW'($urandom);
  endtask

  task automatic wait_ready(input logic [RegAddrW-1:0] addr);
    int unsigned n;
    n = 0;
    while (!reg_rdy[addr] && n < WaitLimit) begin
      @(posedge clk_i);
      n++;
    end
    if (!reg_rdy[addr]) begin
      $display("Timeout: register %0d never became ready after its revocation", addr);
      tmo_cnt++;
    end
  endtask

  initial begin : stimulus
    rf_wb_t              w;
    logic [RegAddrW-1:0] a;
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    wb      = '0;
    rsv     = '0;
    rvk     = '0;
    raddr_a = '0;
    raddr_b = '0;
    rd_next = '0;
    tmo_cnt = 0;
    void'($urandom(32'h79a7));
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset values on every address
    for (int i = 0; i < NumRegs; i++) begin
      rd_next = RegAddrW'(i);
      drive_cycle('0, '0, '0);
    end

    // Back-to-back writebacks including register 0
    repeat (200) drive_cycle(rand_wb(RegAddrW'($urandom)), '0, '0);

    // Reservations mixed with writebacks
    for (int i = 0; i < 150; i++) begin
      w       = rand_wb(RegAddrW'($urandom));
      w.valid = 1'($urandom);
      a       = RegAddrW'($urandom);
      drive_cycle(w, rf_rsv_t'({1'($urandom), a}), '0);
    end
    drive_cycle(rand_wb(RegAddrW'(7)), rf_rsv_t'({1'b1, RegAddrW'(7)}), '0);
    drive_cycle('0, '0, '0);

    // Revocation on an idle port with and without clrtag
    for (int i = 0; i < 20; i++) begin
      a         = RegAddrW'($urandom);
      w         = rand_wb(a);
      w.cap.tag = 1'b1;
      drive_cycle(w, '0, '0);
      drive_cycle('0, rf_rsv_t'({1'b1, a}), '0);
      drive_cycle('0, '0, rf_rvk_t'({1'b1, a, 1'(i % 2)}));
      // Port A stays on the revoked register until it is ready
      rd_next = a;
      drive_cycle('0, '0, '0);
      wait_ready(a);
    end

    // Revocations behind writeback traffic where the fifth one overflows
    for (int i = 0; i < 5; i++) begin
      drive_cycle('0, rf_rsv_t'({1'b1, RegAddrW'(i + 8)}), '0);
    end
    for (int i = 0; i < 8; i++) begin
      drive_cycle(rand_wb(RegAddrW'(i + 20)), '0,
                  rf_rvk_t'({i < 5, RegAddrW'(i + 8), 1'b1}));
    end
    drive_cycle('0, '0, '0);
    wait_ready(RegAddrW'(11));
    repeat (4) drive_cycle('0, '0, '0);

    @(negedge clk_i);
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", chk_cnt, err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0 && chk_cnt != 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- capreg_top.f
hdl/cap_pkg.sv
hdl/rf_pkg.sv
hdl/capreg_bank.sv
hdl/capreg_revoke_queue.sv
hdl/capreg_top.sv
tests/capreg_checker.sv
tests/capreg_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the capability register file testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module capreg_tb -f capreg_top.f -o capreg_sim

out=$(./obj_dir/capreg_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
else
  exit 1
fi
